// ==== bench/plru_checker.sv ====
//--------------------------------------------------------------------------
// PLRU response checker
// Keeps a model tree word per set, predicts each response two cycles
// after its strobe and compares it with the DUT outputs
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_checker (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 req_valid_i,
    input  wire logic                 req_evict_i,
    input  wire plru_pkg::set_index_t req_index_i,
    input  wire plru_pkg::way_vec_t   hit_way_i,
    input  wire plru_pkg::way_vec_t   tag_valid_i,
    input  wire plru_pkg::way_vec_t   tag_dirty_i,
    input  wire plru_pkg::way_vec_t   spm_lock_i,
    input  wire logic                 resp_valid_i,
    input  wire logic                 resp_evict_i,
    input  wire logic                 writeback_i,
    input  wire plru_pkg::way_vec_t   victim_way_i,
    output      logic                 idle_o,
    output      int                   checks_o,
    output      int                   errors_o
);

    // Bit 0 root, bits 3..1 ways 7..4, bits 6..4 ways 3..0
    logic [6:0]      words [plru_pkg::NUM_SETS];
    // Expected responses indexed by cycle modulo 4
    logic [3:0]      exp_valid = '0;
    logic [3:0]      exp_evict = '0;
    logic [3:0]      exp_wb = '0;
    logic [3:0][7:0] exp_victim = '0;
    logic [3:0][7:0] exp_avoid = '0;
    int              cycle = 0;
    int              checks = 0;
    int              errors = 0;
    logic            reset_seen = 1'b0;
    logic            active = 1'b0;
    logic [1:0]      wslot;
    logic [1:0]      rslot;
    logic [7:0]      mask;
    logic [6:0]      nw;
    int              vic;

    assign idle_o   = (exp_valid == 4'b0000);
    assign checks_o = checks;
    assign errors_o = errors;

    // Upper side full gives 1, lower side full gives 0, else flip
    function automatic logic side_bit(input logic old_bit, input logic up_full,
                                      input logic lo_full);
        if (up_full) begin
            return 1'b1;
        end else if (lo_full) begin
            return 1'b0;
        end
        return ~old_bit;
    endfunction

    function automatic logic [6:0] apply_hit(input logic [6:0] w, input logic [7:0] hit);
        logic [6:0] res;
        int         h;
        int         rel;
        int         base;
        res = w;
        h   = 0;
        for (int i = 0; i < 8; i++) begin
            if (hit[i]) begin
                h = i;
            end
        end
        res[0]    = (h < 4);
        base      = (h >= 4) ? 1 : 4;
        rel       = h % 4;
        res[base] = (rel < 2);
        if (rel >= 2) begin
            res[base+1] = (rel == 2);
        end else begin
            res[base+2] = (rel == 0);
        end
        return res;
    endfunction

    task automatic walk_victim(input logic [6:0] w, input logic [7:0] m, input logic [7:0] lock,
                               output logic [6:0] res, output int way);
        logic [3:0] hm;
        int         top;
        int         base;
        int         pb;
        int         up;
        int         lo;
        res    = w;
        res[0] = side_bit(w[0], &m[7:4], &m[3:0]);
        top    = res[0] ? 0 : 4;
        base   = res[0] ? 4 : 1;
        hm     = m[top +: 4];
        res[base] = side_bit(w[base], &hm[3:2], &hm[1:0]);
        pb = res[base] ? base + 2 : base + 1;
        up = res[base] ? top + 1 : top + 3;
        lo = up - 1;
        if (lock[up] && !lock[lo]) begin
            res[pb] = 1'b1;
        end else if (!lock[up] && lock[lo]) begin
            res[pb] = 1'b0;
        end else begin
            res[pb] = ~w[pb];
        end
        way = res[pb] ? lo : up;
    endtask

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h in cycle %0d", name, got, exp, cycle);
            errors = errors + 1;
        end
    endtask

    // Inputs are stable at the rising edge
    always @(posedge clk_i) begin
        cycle              = cycle + 1;
        wslot              = cycle[1:0] + 2'd1;
        exp_valid[wslot]   = 1'b0;
        exp_evict[wslot]   = 1'b0;
        exp_wb[wslot]      = 1'b0;
        exp_victim[wslot]  = 8'h00;
        exp_avoid[wslot]   = 8'h00;
        if (reset_i) begin
            for (int i = 0; i < plru_pkg::NUM_SETS; i++) begin
                words[i] = 7'd0;
            end
            reset_seen = 1'b1;
            active     = 1'b0;
        end else begin
            active = reset_seen;
            if (req_valid_i) begin
                exp_valid[wslot] = 1'b1;
                if (req_evict_i) begin
                    mask = tag_valid_i | spm_lock_i;
                    if (mask == 8'hFF) begin
                        mask = spm_lock_i;
                    end
                    walk_victim(words[req_index_i], mask, spm_lock_i, nw, vic);
                    words[req_index_i] = nw;
                    exp_evict[wslot]   = 1'b1;
                    exp_victim[wslot]  = 8'b1 << vic;
                    exp_wb[wslot]      = tag_dirty_i[vic];
                    if (&mask[7:4] && !(&mask[3:0])) begin
                        exp_avoid[wslot] = 8'hF0;
                    end else if (&mask[3:0] && !(&mask[7:4])) begin
                        exp_avoid[wslot] = 8'h0F;
                    end
                end else begin
                    words[req_index_i] = apply_hit(words[req_index_i], hit_way_i);
                end
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        rslot = cycle[1:0];
        if (active) begin
            checks = checks + 1;
            compare_value("resp_valid_o", {7'b0, resp_valid_i}, {7'b0, exp_valid[rslot]});
            compare_value("resp_evict_o", {7'b0, resp_evict_i}, {7'b0, exp_evict[rslot]});
            compare_value("writeback_o", {7'b0, writeback_i}, {7'b0, exp_wb[rslot]});
            compare_value("victim_way_o", victim_way_i, exp_victim[rslot]);
            if (exp_evict[rslot] && |(victim_way_i & exp_avoid[rslot])) begin
                $display("victim %h was taken from a full half while the other had room",
                         victim_way_i);
                errors = errors + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_plru.sv ====
//--------------------------------------------------------------------------
// Testbench for the tree pseudo-LRU unit
// Clock, reset, LFSR driven requests and the response checker
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_plru;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req_valid;
    logic                 req_evict;
    plru_pkg::set_index_t req_index;
    plru_pkg::way_vec_t   hit_way;
    plru_pkg::way_vec_t   tag_valid;
    plru_pkg::way_vec_t   tag_dirty;
    plru_pkg::way_vec_t   spm_lock;
    logic                 resp_valid;
    logic                 resp_evict;
    logic                 writeback;
    plru_pkg::way_vec_t   victim_way;
    logic                 idle;
    int                   checks;
    int                   errors;
    logic [15:0]          lfsr;

    always #4 clk = ~clk;

    plru_top dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .req_valid_i  (req_valid),
        .req_evict_i  (req_evict),
        .req_index_i  (req_index),
        .hit_way_i    (hit_way),
        .tag_valid_i  (tag_valid),
        .tag_dirty_i  (tag_dirty),
        .spm_lock_i   (spm_lock),
        .resp_valid_o (resp_valid),
        .resp_evict_o (resp_evict),
        .writeback_o  (writeback),
        .victim_way_o (victim_way)
    );

    plru_checker u_checker (
        .clk_i        (clk),
        .reset_i      (reset),
        .req_valid_i  (req_valid),
        .req_evict_i  (req_evict),
        .req_index_i  (req_index),
        .hit_way_i    (hit_way),
        .tag_valid_i  (tag_valid),
        .tag_dirty_i  (tag_dirty),
        .spm_lock_i   (spm_lock),
        .resp_valid_i (resp_valid),
        .resp_evict_i (resp_evict),
        .writeback_i  (writeback),
        .victim_way_i (victim_way),
        .idle_o       (idle),
        .checks_o     (checks),
        .errors_o     (errors)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        logic       fb;
        val = 8'h00;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[6:0], fb};
        end
        return val;
    endfunction

    task automatic send_request(input logic evict, input plru_pkg::set_index_t index,
                                input plru_pkg::way_vec_t hit, input plru_pkg::way_vec_t valid,
                                input plru_pkg::way_vec_t dirty, input plru_pkg::way_vec_t lock);
        @(negedge clk);
        req_valid = 1'b1;
        req_evict = evict;
        req_index = index;
        hit_way   = hit;
        tag_valid = valid;
        tag_dirty = dirty;
        spm_lock  = lock;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_random(input plru_pkg::set_index_t index);
        plru_pkg::way_vec_t hit;
        plru_pkg::way_vec_t valid;
        plru_pkg::way_vec_t lock;
        logic               evict;
        hit   = 8'b1 << rand_bits(3);
        valid = rand_bits(8) | rand_bits(8);
        lock  = rand_bits(8) & rand_bits(8) & rand_bits(8);
        evict = 1'(rand_bits(1));
        send_request(evict, index, hit, valid, rand_bits(8), lock);
    endtask

    initial begin
        plru_pkg::set_index_t idx;
        plru_pkg::way_vec_t   valid;
        plru_pkg::way_vec_t   lock;
        int                   t;
        lfsr      = 16'd14;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_evict = 1'b0;
        req_index = '0;
        hit_way   = '0;
        tag_valid = '0;
        tag_dirty = '0;
        spm_lock  = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        idle_cycles(4);
        // Fresh set, all ways valid, nothing locked
        send_request(1'b1, 4'd0, 8'h00, 8'hFF, 8'h01, 8'h00);
        idle_cycles(3);
        // Random hits and evicts over all sets
        repeat (200) begin
            idx = 4'(rand_bits(4));
            if (rand_bits(2) != 8'd0) begin
                send_request(1'b0, idx, 8'b1 << rand_bits(3), 8'hFF, rand_bits(8), 8'h00);
            end else begin
                send_request(1'b1, idx, 8'h00, 8'hFF, rand_bits(8), 8'h00);
            end
            if (rand_bits(2) == 8'd0) begin
                idle_cycles(1);
            end
        end
        // One half fully occupied, free ways only in the other
        repeat (100) begin
            idx   = 4'(rand_bits(4));
            valid = rand_bits(8);
            if (rand_bits(1) != 8'd0) begin
                valid[7:4] = 4'hF;
            end else begin
                valid[3:0] = 4'hF;
            end
            send_request(1'b1, idx, 8'h00, valid, rand_bits(8), 8'h00);
            send_request(1'b0, idx, 8'b1 << rand_bits(3), valid, rand_bits(8), 8'h00);
        end
        // All valid, one half fully locked
        repeat (100) begin
            idx = 4'(rand_bits(4));
            if (rand_bits(1) != 8'd0) begin
                lock = {4'hF, 1'b0, 3'(rand_bits(3))};
            end else begin
                lock = {1'b0, 3'(rand_bits(3)), 4'hF};
            end
            send_request(1'b1, idx, 8'h00, 8'hFF, rand_bits(8), lock);
            send_request(1'b0, idx, 8'b1 << rand_bits(3), 8'hFF, rand_bits(8), lock);
        end
        // Bursts to one set exercise the store forwarding path
        repeat (20) begin
            idx = 4'(rand_bits(4));
            repeat (6) begin
                send_random(idx);
            end
            idle_cycles(2);
        end
        idle_cycles(1);
        for (t = 0; t < 20 && !idle; t++) begin
            @(negedge clk);
        end
        if (!idle) begin
            $display("timeout while waiting for the outstanding responses");
            $display("=== FAIL ===");
            $finish;
        end else begin
            $display("checks %0d errors %0d", checks, errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/plru_pkg.sv ====
//--------------------------------------------------------------------------
// Tree pseudo-LRU package
// Sizes, way vector and set index types, and the 7-bit tree word
// with its flat and structured views
//--------------------------------------------------------------------------
`default_nettype none

package plru_pkg;

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 16;
    localparam int INDEX_W  = 4;
    localparam int TREE_W   = NUM_WAYS - 1;

    // One bit per way, way 7 in the MSB
    typedef logic [NUM_WAYS-1:0] way_vec_t;

    typedef logic [INDEX_W-1:0] set_index_t;

    // Per half: [0] half root, [1] upper pair select, [2] lower pair select
    // A bit value of 0 points to the upper side, 1 to the lower side
    typedef union packed {
        logic [TREE_W-1:0] flat;
        struct packed {
            logic [2:0] lower_half;
            logic [2:0] upper_half;
            logic       root;
        } tree;
    } plru_tree_u;

endpackage

`default_nettype wire

// ==== rtl/plru_req_if.sv ====
//--------------------------------------------------------------------------
// Captured PLRU request
// Carries one registered request from the request stage to the tree
// logic and the response stage
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface plru_req_if;

    logic                 valid;
    // 1 for victim selection, 0 for hit update
    logic                 evict;
    plru_pkg::set_index_t index;
    plru_pkg::way_vec_t   hit_way;
    // Valid or locked ways
    plru_pkg::way_vec_t   occupied;
    plru_pkg::way_vec_t   spm_lock;
    plru_pkg::way_vec_t   dirty;

    modport source (
        output valid, evict, index, hit_way, occupied, spm_lock, dirty
    );

    modport sink (
        input valid, evict, index, hit_way, occupied, spm_lock, dirty
    );

endinterface

`default_nettype wire

// ==== rtl/plru_req_stage.sv ====
//--------------------------------------------------------------------------
// PLRU request stage
// Captures the request on the strobe and starts the tree word read
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_req_stage (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 req_valid_i,
    input  wire logic                 req_evict_i,
    input  wire plru_pkg::set_index_t req_index_i,
    input  wire plru_pkg::way_vec_t   hit_way_i,
    input  wire plru_pkg::way_vec_t   tag_valid_i,
    input  wire plru_pkg::way_vec_t   tag_dirty_i,
    input  wire plru_pkg::way_vec_t   spm_lock_i,
    output      plru_pkg::set_index_t rd_index_o,
    plru_req_if.source                req
);

    // Store read is issued in the strobe cycle, data arrives with req.valid
    assign rd_index_o = req_index_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            req.evict    <= req_evict_i;
            req.index    <= req_index_i;
            req.hit_way  <= hit_way_i;
            // A locked way counts as taken even when its tag is invalid
            req.occupied <= tag_valid_i | spm_lock_i;
            req.spm_lock <= spm_lock_i;
            req.dirty    <= tag_dirty_i;
        end
    end

    // Hit updates only make sense for exactly one hit way
    a_hit_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        req_valid_i && !req_evict_i |-> $onehot(hit_way_i)
    );

endmodule

`default_nettype wire

// ==== rtl/plru_resp_stage.sv ====
//--------------------------------------------------------------------------
// PLRU response stage
// Registers the result and flags a dirty victim for write-back
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_resp_stage (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    plru_req_if.sink                req,
    input  wire plru_pkg::way_vec_t victim_way_i,
    output      logic               resp_valid_o,
    output      logic               resp_evict_o,
    output      logic               writeback_o,
    output      plru_pkg::way_vec_t victim_way_o
);

    logic evict_now;

    assign evict_now = req.valid && req.evict;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
            resp_evict_o <= 1'b0;
            writeback_o  <= 1'b0;
            victim_way_o <= '0;
        end else begin
            resp_valid_o <= req.valid;
            resp_evict_o <= evict_now;
            // Hit responses and idle cycles show no victim
            victim_way_o <= evict_now ? victim_way_i : '0;
            writeback_o  <= evict_now && |(victim_way_i & req.dirty);
        end
    end

    // Victim comes out of the tree walk one stage earlier
    a_victim_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        resp_valid_o && resp_evict_o |-> $onehot(victim_way_o)
    );

endmodule

`default_nettype wire

// ==== rtl/plru_state_store.sv ====
//--------------------------------------------------------------------------
// PLRU state store
// One tree word per set, cleared on reset, registered read with
// forwarding of a same-cycle write
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_state_store (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire plru_pkg::set_index_t rd_index_i,
    output      plru_pkg::plru_tree_u rd_word_o,
    input  wire logic                 wr_en_i,
    input  wire plru_pkg::set_index_t wr_index_i,
    input  wire plru_pkg::plru_tree_u wr_word_i
);

    plru_pkg::plru_tree_u words [plru_pkg::NUM_SETS];
    logic                 fwd;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < plru_pkg::NUM_SETS; i++) begin
                words[i].flat <= '0;
            end
        end else if (wr_en_i) begin
            words[wr_index_i].flat <= wr_word_i.flat;
        end
    end

    // Back-to-back requests to one set need the word being written now
    assign fwd = wr_en_i && (wr_index_i == rd_index_i);

    always_ff @(posedge clk_i) begin
        if (fwd) begin
            rd_word_o.flat <= wr_word_i.flat;
        end else begin
            rd_word_o.flat <= words[rd_index_i].flat;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/plru_top.sv ====
//--------------------------------------------------------------------------
// Tree pseudo-LRU replacement unit, 8 ways by 16 sets
// Hit update and victim selection with a fixed 2-cycle response
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_top (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 req_valid_i,
    input  wire logic                 req_evict_i,
    input  wire plru_pkg::set_index_t req_index_i,
    input  wire plru_pkg::way_vec_t   hit_way_i,
    input  wire plru_pkg::way_vec_t   tag_valid_i,
    input  wire plru_pkg::way_vec_t   tag_dirty_i,
    input  wire plru_pkg::way_vec_t   spm_lock_i,
    output      logic                 resp_valid_o,
    output      logic                 resp_evict_o,
    output      logic                 writeback_o,
    output      plru_pkg::way_vec_t   victim_way_o
);

    plru_pkg::set_index_t rd_index;
    plru_pkg::plru_tree_u rd_word;
    logic                 wr_en;
    plru_pkg::set_index_t wr_index;
    plru_pkg::plru_tree_u wr_word;
    plru_pkg::way_vec_t   victim_way;

    plru_req_if req_if ();

    plru_req_stage u_req_stage (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_evict_i (req_evict_i),
        .req_index_i (req_index_i),
        .hit_way_i   (hit_way_i),
        .tag_valid_i (tag_valid_i),
        .tag_dirty_i (tag_dirty_i),
        .spm_lock_i  (spm_lock_i),
        .rd_index_o  (rd_index),
        .req         (req_if.source)
    );

    plru_state_store u_state_store (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_index_i (rd_index),
        .rd_word_o  (rd_word),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_word_i  (wr_word)
    );

    // Combinational in the cycle after capture
    plru_tree_update u_tree_update (
        .req          (req_if.sink),
        .cur_word_i   (rd_word),
        .wr_en_o      (wr_en),
        .wr_index_o   (wr_index),
        .wr_word_o    (wr_word),
        .victim_way_o (victim_way)
    );

    plru_resp_stage u_resp_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req          (req_if.sink),
        .victim_way_i (victim_way),
        .resp_valid_o (resp_valid_o),
        .resp_evict_o (resp_evict_o),
        .writeback_o  (writeback_o),
        .victim_way_o (victim_way_o)
    );

endmodule

`default_nettype wire

// ==== rtl/plru_tree_update.sv ====
//--------------------------------------------------------------------------
// PLRU tree logic
// Rewrites the hit path or walks the tree to pick a victim, and
// writes the new tree word back to the store
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module plru_tree_update (
    plru_req_if.sink                  req,
    input  wire plru_pkg::plru_tree_u cur_word_i,
    output      logic                 wr_en_o,
    output      plru_pkg::set_index_t wr_index_o,
    output      plru_pkg::plru_tree_u wr_word_o,
    output      plru_pkg::way_vec_t   victim_way_o
);

    plru_pkg::plru_tree_u new_word;
    plru_pkg::way_vec_t   test_mask;
    logic [2:0]           half_new;
    logic [3:0]           half_way;

    // Node above two subtrees: avoid a full side, else flip
    function automatic logic level_bit(input logic old_bit, input logic [1:0] full);
        if (full[1]) begin
            return 1'b1;
        end else if (full[0]) begin
            return 1'b0;
        end
        return ~old_bit;
    endfunction

    // Pair node, steered by the SPM lock of its two ways
    function automatic logic pair_bit(input logic old_bit, input logic [1:0] lock);
        if (lock == 2'b10) begin
            return 1'b1;
        end else if (lock == 2'b01) begin
            return 1'b0;
        end
        return ~old_bit;
    endfunction

    // Hit path within one half, ways given as [upper .. lower]
    function automatic logic [2:0] half_hit(input logic [2:0] half, input logic [3:0] ways);
        logic [2:0] res;
        res = half;
        if (|ways[3:2]) begin
            res[0] = 1'b0;
            res[1] = ways[2];
        end else if (|ways[1:0]) begin
            res[0] = 1'b1;
            res[2] = ways[0];
        end
        return res;
    endfunction

    // Victim walk within one half
    function automatic void half_walk(
        input  logic [2:0] half,
        input  logic [3:0] mask,
        input  logic [3:0] lock,
        output logic [2:0] res,
        output logic [3:0] way
    );
        res    = half;
        res[0] = level_bit(half[0], {&mask[3:2], &mask[1:0]});
        if (!res[0]) begin
            res[1] = pair_bit(half[1], lock[3:2]);
            way    = res[1] ? 4'b0100 : 4'b1000;
        end else begin
            res[2] = pair_bit(half[2], lock[1:0]);
            way    = res[2] ? 4'b0001 : 4'b0010;
        end
    endfunction

    // Once every way is taken only the lock pattern can steer the walk
    assign test_mask = (&req.occupied) ? req.spm_lock : req.occupied;

    always_comb begin
        new_word     = cur_word_i;
        victim_way_o = '0;
        half_new     = '0;
        half_way     = '0;
        if (req.evict) begin
            new_word.tree.root = level_bit(cur_word_i.tree.root,
                                           {&test_mask[7:4], &test_mask[3:0]});
            if (!new_word.tree.root) begin
                half_walk(cur_word_i.tree.upper_half, test_mask[7:4], req.spm_lock[7:4],
                          half_new, half_way);
                new_word.tree.upper_half = half_new;
                victim_way_o[7:4]        = half_way;
            end else begin
                half_walk(cur_word_i.tree.lower_half, test_mask[3:0], req.spm_lock[3:0],
                          half_new, half_way);
                new_word.tree.lower_half = half_new;
                victim_way_o[3:0]        = half_way;
            end
        end else if (|req.hit_way[7:4]) begin
            new_word.tree.root       = 1'b0;
            new_word.tree.upper_half = half_hit(cur_word_i.tree.upper_half, req.hit_way[7:4]);
        end else if (|req.hit_way[3:0]) begin
            new_word.tree.root       = 1'b1;
            new_word.tree.lower_half = half_hit(cur_word_i.tree.lower_half, req.hit_way[3:0]);
        end
    end

    assign wr_en_o    = req.valid;
    assign wr_index_o = req.index;
    assign wr_word_o  = new_word;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_plru > build.log 2>&1 \
    && ./obj_dir/Vtb_plru > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// ==== verilog.f ====
rtl/plru_pkg.sv
rtl/plru_req_if.sv
rtl/plru_req_stage.sv
rtl/plru_state_store.sv
rtl/plru_tree_update.sv
rtl/plru_resp_stage.sv
rtl/plru_top.sv
bench/plru_checker.sv
bench/tb_plru.sv
